// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = l1_cache_tb
FILELIST = l1_cache.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/bus_arbiter.sv ====
/*
 * Merges the two caches onto the tagged memory bus, one transaction at a
 * time. Grant is combinational from registered state so no cycles are added.
 * Responses are routed by the source field of the response tag.
 */
`timescale 1ns/1ps

module bus_arbiter
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_req_cyc,
  input  bus_word_t instr_req,
  input  bus_tag_t  instr_req_tag,
  input  logic      instr_req_last,
  input  logic      instr_resp_ack,
  output logic      instr_req_ack,
  output logic      instr_resp_cyc,
  output bus_word_t instr_resp_data,
  input  logic      data_req_cyc,
  input  bus_word_t data_req,
  input  bus_tag_t  data_req_tag,
  input  logic      data_req_last,
  input  logic      data_resp_ack,
  output logic      data_req_ack,
  output logic      data_resp_cyc,
  output bus_word_t data_resp_data,
  output logic      bus_reqcyc,
  output bus_word_t bus_req,
  output bus_tag_t  bus_reqtag,
  output logic      bus_respack,
  input  logic      bus_reqack,
  input  logic      bus_respcyc,
  input  bus_word_t bus_resp,
  input  bus_tag_t  bus_resptag
);

  arb_state_t state;
  logic       last_data;
  logic       read_txn;
  beat_t      resp_beats;

  logic                 pick_instr;
  logic                 grant_instr;
  logic                 grant_data;
  logic                 granted_last;
  logic                 txn_end;
  logic [BUS_TAG_W-2:0] resp_src;

  // Tie break favours whichever cache lost last time
  assign pick_instr  = instr_req_cyc && !(data_req_cyc && !last_data);
  assign grant_instr = (state == ARB_INSTR) || (state == ARB_IDLE && pick_instr);
  assign grant_data  = (state == ARB_DATA) || (state == ARB_IDLE && !pick_instr && data_req_cyc);

  // Request channel mux
  assign bus_reqcyc    = grant_instr ? instr_req_cyc  : grant_data && data_req_cyc;
  assign bus_req       = grant_instr ? instr_req      : data_req;
  assign bus_reqtag    = grant_instr ? instr_req_tag  : data_req_tag;
  assign granted_last  = grant_instr ? instr_req_last : data_req_last;
  assign instr_req_ack = grant_instr && bus_reqack;
  assign data_req_ack  = grant_data && bus_reqack;

  // Responses go where the tag says
  assign resp_src        = bus_resptag[BUS_TAG_W-2:0];
  assign instr_resp_cyc  = bus_respcyc && resp_src == SRC_INSTR[BUS_TAG_W-2:0];
  assign data_resp_cyc   = bus_respcyc && resp_src == SRC_DATA[BUS_TAG_W-2:0];
  assign instr_resp_data = bus_resp;
  assign data_resp_data  = bus_resp;
  assign bus_respack     = grant_instr ? instr_resp_ack : grant_data && data_resp_ack;

  // Read ends on the 8th acked beat, write-back on its acked last beat
  assign txn_end = read_txn ? (bus_respcyc && bus_respack && resp_beats == beat_t'(BEATS - 1))
                            : (bus_reqcyc && bus_reqack && granted_last);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state      <= ARB_IDLE;
      last_data  <= 1'b0;
      read_txn   <= 1'b0;
      resp_beats <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          resp_beats <= '0;
          if (grant_instr || grant_data) begin
            state     <= grant_instr ? ARB_INSTR : ARB_DATA;
            last_data <= grant_data;
            read_txn  <= bus_reqtag[BUS_TAG_W-1] == MEM_READ[BUS_TAG_W-1];
          end
        end
        ARB_INSTR, ARB_DATA: begin
          if (bus_respcyc && bus_respack) begin
            resp_beats <= resp_beats + 1'b1;
          end
          if (txn_end) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  a_resp_src: assert property (@(posedge clk) disable iff (!reset)
    bus_respcyc |-> (grant_instr && resp_src == SRC_INSTR[BUS_TAG_W-2:0]) ||
                    (grant_data && resp_src == SRC_DATA[BUS_TAG_W-2:0]));

  // Beats of a locked transaction keep the operation it started with
  a_grant_locked: assert property (@(posedge clk) disable iff (!reset)
    state != ARB_IDLE && bus_reqcyc |->
      (bus_reqtag[BUS_TAG_W-1] == MEM_READ[BUS_TAG_W-1]) == read_txn);

endmodule

// ==== hw/cache_pkg.sv ====
/*
 * Shared widths, address fields and bus tag codes for both L1 caches.
 * Address split is tag[31:10], index[9:6], offset[5:0]; the bus moves one
 * 64-bit beat per cycle, eight beats per line.
 */
package cache_pkg;

  // Processor and bus widths
  localparam int ADDR_W    = 32;
  localparam int BUS_W     = 64;
  localparam int INSTR_W   = 32;
  localparam int WORD_W    = 64;

  // Cache geometry, 4 KB per cache
  localparam int WAYS      = 4;
  localparam int SETS      = 16;
  localparam int BEATS     = 8;
  localparam int OFFSET_W  = 6;
  localparam int INDEX_W   = 4;
  localparam int TAG_W     = 22;
  localparam int BUS_TAG_W = 4;

  typedef logic [ADDR_W-1:0]          addr_t;
  typedef logic [BUS_W-1:0]           bus_word_t;
  typedef logic [INSTR_W-1:0]         instr_t;
  typedef logic [WORD_W-1:0]          word_t;
  typedef logic [TAG_W-1:0]           line_tag_t;
  typedef logic [INDEX_W-1:0]         set_index_t;
  typedef logic [$clog2(BEATS)-1:0]   beat_t;
  typedef logic [$clog2(WAYS)-1:0]    way_t;
  typedef logic [BUS_TAG_W-1:0]       bus_tag_t;

  // Bus tag is {operation, source}; OR one code of each kind together
  localparam bus_tag_t MEM_READ  = 4'b1000;
  localparam bus_tag_t MEM_WRITE = 4'b0000;
  localparam bus_tag_t SRC_INSTR = 4'b0001;
  localparam bus_tag_t SRC_DATA  = 4'b0010;

  typedef enum logic [2:0] {
    IC_IDLE,
    IC_LOOKUP,
    IC_REQUEST,
    IC_FILL,
    IC_RESPOND
  } icache_state_t;

  typedef enum logic [2:0] {
    DC_IDLE,
    DC_LOOKUP,
    DC_WB_REQUEST,
    DC_WB_DATA,
    DC_REQUEST,
    DC_FILL,
    DC_RESPOND
  } dcache_state_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_INSTR,
    ARB_DATA
  } arb_state_t;

endpackage

// ==== hw/data_cache.sv ====
/*
 * Write-back, write-allocate 4-way data cache for aligned 64-bit words.
 * A dirty victim is written back (address beat, then 8 data beats) before
 * the refill. Whole-word writes only; one miss at a time.
 */
`timescale 1ns/1ps

module data_cache
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      mem_read,
  input  logic      mem_write,
  input  addr_t     data_address,
  input  word_t     write_data,
  output word_t     data_response,
  output logic      data_ready,
  output logic      req_cyc,
  output bus_word_t req,
  output bus_tag_t  req_tag,
  output logic      req_last,
  output logic      resp_ack,
  input  logic      req_ack,
  input  logic      resp_cyc,
  input  bus_word_t resp_data
);

  dcache_state_t state;
  addr_t         addr_q;
  word_t         write_q;
  logic          is_write_q;
  beat_t         beat;

  logic [SETS-1:0][WAYS-1:0] valid;
  logic [SETS-1:0][WAYS-1:0] dirty;
  way_t [SETS-1:0]           victim_ptr;

  line_tag_t tag_mem [SETS][WAYS];
  bus_word_t data_mem [WAYS][SETS][BEATS];

  line_tag_t  tag_q;
  set_index_t index_q;
  beat_t      word_beat;
  way_t       victim;
  way_t       hit_way;
  logic       hit;
  logic       take_beat;
  bus_word_t  fill_word;
  addr_t      line_addr;
  addr_t      victim_addr;

  assign tag_q       = addr_q[ADDR_W-1 -: TAG_W];
  assign index_q     = addr_q[OFFSET_W +: INDEX_W];
  assign word_beat   = addr_q[OFFSET_W-1 -: $bits(beat_t)];
  assign victim      = victim_ptr[index_q];
  assign line_addr   = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign victim_addr = {tag_mem[index_q][victim], index_q, {OFFSET_W{1'b0}}};
  assign take_beat   = (state == DC_FILL) && resp_cyc && !resp_ack;
  assign data_ready  = (state == DC_RESPOND);

  // Write miss merges the store into the incoming line
  assign fill_word = (is_write_q && beat == word_beat) ? write_q : resp_data;

  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (valid[index_q][w] && tag_mem[index_q][w] == tag_q) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Request channel follows the FSM
  always_comb begin
    req_cyc  = 1'b0;
    req      = {{(BUS_W-ADDR_W){1'b0}}, line_addr};
    req_tag  = MEM_READ | SRC_DATA;
    req_last = 1'b0;
    case (state)
      DC_WB_REQUEST: begin
        req_cyc = 1'b1;
        req     = {{(BUS_W-ADDR_W){1'b0}}, victim_addr};
        req_tag = MEM_WRITE | SRC_DATA;
      end
      DC_WB_DATA: begin
        req_cyc  = 1'b1;
        req      = data_mem[victim][index_q][beat];
        req_tag  = MEM_WRITE | SRC_DATA;
        req_last = (beat == beat_t'(BEATS - 1));
      end
      DC_REQUEST: begin
        req_cyc  = 1'b1;
        req_last = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state      <= DC_IDLE;
      beat       <= '0;
      resp_ack   <= 1'b0;
      valid      <= '0;
      dirty      <= '0;
      victim_ptr <= '0;
    end else begin
      resp_ack <= take_beat;
      case (state)
        DC_IDLE: begin
          if (mem_read || mem_write) begin
            state <= DC_LOOKUP;
          end
        end
        DC_LOOKUP: begin
          if (hit) begin
            if (is_write_q) begin
              dirty[index_q][hit_way] <= 1'b1;
            end
            state <= DC_RESPOND;
          end else if (valid[index_q][victim] && dirty[index_q][victim]) begin
            state <= DC_WB_REQUEST;
          end else begin
            state <= DC_REQUEST;
          end
        end
        DC_WB_REQUEST: begin
          if (req_ack) begin
            beat  <= '0;
            state <= DC_WB_DATA;
          end
        end
        DC_WB_DATA: begin
          if (req_ack) begin
            beat <= beat + 1'b1;
            if (beat == beat_t'(BEATS - 1)) begin
              dirty[index_q][victim] <= 1'b0;
              state                  <= DC_REQUEST;
            end
          end
        end
        DC_REQUEST: begin
          if (req_ack) begin
            valid[index_q][victim] <= 1'b0;
            beat                   <= '0;
            state                  <= DC_FILL;
          end
        end
        DC_FILL: begin
          if (take_beat) begin
            beat <= beat + 1'b1;
            if (beat == beat_t'(BEATS - 1)) begin
              valid[index_q][victim] <= 1'b1;
              dirty[index_q][victim] <= is_write_q;
              victim_ptr[index_q]    <= victim + 1'b1;
              state                  <= DC_RESPOND;
            end
          end
        end
        DC_RESPOND: state <= DC_IDLE;
        default:    state <= DC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DC_IDLE) begin
      addr_q     <= data_address;
      write_q    <= write_data;
      is_write_q <= mem_write;
    end
    if (state == DC_LOOKUP && hit) begin
      if (is_write_q) begin
        data_mem[hit_way][index_q][word_beat] <= write_q;
      end else begin
        data_response <= data_mem[hit_way][index_q][word_beat];
      end
    end
    if (take_beat) begin
      data_mem[victim][index_q][beat] <= fill_word;
      if (beat == word_beat) begin
        data_response <= resp_data;
      end
      if (beat == beat_t'(BEATS - 1)) begin
        tag_mem[index_q][victim] <= tag_q;
      end
    end
  end

  a_one_op: assert property (@(posedge clk) disable iff (!reset)
    !(mem_read && mem_write));

  // Held request beat must not move before the arbiter takes it
  a_req_held: assert property (@(posedge clk) disable iff (!reset)
    req_cyc && !req_ack |=> req_cyc && $stable(req) && $stable(req_tag));

endmodule

// ==== hw/instr_cache.sv ====
/*
 * Read-only 4-way instruction cache, 16 sets of 64-byte lines.
 * Hit answers 2 cycles after the request is sampled; a miss fetches the
 * whole line and answers when the last beat is in. One miss at a time.
 */
`timescale 1ns/1ps

module instr_cache
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_read,
  input  addr_t     instr_address,
  output instr_t    instr_data,
  output logic      instr_ready,
  output logic      req_cyc,
  output bus_word_t req,
  output bus_tag_t  req_tag,
  output logic      req_last,
  output logic      resp_ack,
  input  logic      req_ack,
  input  logic      resp_cyc,
  input  bus_word_t resp_data
);

  icache_state_t state;
  addr_t         addr_q;
  beat_t         beat;

  // Per-set control bits
  logic [SETS-1:0][WAYS-1:0] valid;
  way_t [SETS-1:0]           victim_ptr;

  // Tag and line storage
  line_tag_t tag_mem [SETS][WAYS];
  bus_word_t data_mem [WAYS][SETS][BEATS];

  line_tag_t  tag_q;
  set_index_t index_q;
  beat_t      word_beat;
  way_t       victim;
  way_t       hit_way;
  logic       hit;
  logic       take_beat;
  bus_word_t  hit_word;
  addr_t      line_addr;

  assign tag_q     = addr_q[ADDR_W-1 -: TAG_W];
  assign index_q   = addr_q[OFFSET_W +: INDEX_W];
  assign word_beat = addr_q[OFFSET_W-1 -: $bits(beat_t)];
  assign victim    = victim_ptr[index_q];
  assign hit_word  = data_mem[hit_way][index_q][word_beat];
  assign line_addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // Accept each beat once, then hold off while ack is out
  assign take_beat = (state == IC_FILL) && resp_cyc && !resp_ack;

  // Tag compare over all ways of the set
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (valid[index_q][w] && tag_mem[index_q][w] == tag_q) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Single read beat carrying the line address
  assign req_cyc     = (state == IC_REQUEST);
  assign req         = {{(BUS_W-ADDR_W){1'b0}}, line_addr};
  assign req_tag     = MEM_READ | SRC_INSTR;
  assign req_last    = req_cyc;
  assign instr_ready = (state == IC_RESPOND);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state      <= IC_IDLE;
      beat       <= '0;
      resp_ack   <= 1'b0;
      valid      <= '0;
      victim_ptr <= '0;
    end else begin
      resp_ack <= take_beat;
      case (state)
        IC_IDLE: begin
          if (instr_read) begin
            state <= IC_LOOKUP;
          end
        end
        IC_LOOKUP: begin
          state <= hit ? IC_RESPOND : IC_REQUEST;
        end
        IC_REQUEST: begin
          if (req_ack) begin
            // Victim is invalid until its new line is complete
            valid[index_q][victim] <= 1'b0;
            beat                   <= '0;
            state                  <= IC_FILL;
          end
        end
        IC_FILL: begin
          if (take_beat) begin
            beat <= beat + 1'b1;
            if (beat == beat_t'(BEATS - 1)) begin
              valid[index_q][victim] <= 1'b1;
              victim_ptr[index_q]    <= victim + 1'b1;
              state                  <= IC_RESPOND;
            end
          end
        end
        IC_RESPOND: state <= IC_IDLE;
        default:    state <= IC_IDLE;
      endcase
    end
  end

  // Address, storage and answer payload
  always_ff @(posedge clk) begin
    if (state == IC_IDLE && instr_read) begin
      addr_q <= instr_address;
    end
    if (state == IC_LOOKUP && hit) begin
      instr_data <= addr_q[2] ? hit_word[INSTR_W +: INSTR_W] : hit_word[INSTR_W-1:0];
    end
    if (take_beat) begin
      data_mem[victim][index_q][beat] <= resp_data;
      // Answer straight from the fill when the addressed beat goes by
      if (beat == word_beat) begin
        instr_data <= addr_q[2] ? resp_data[INSTR_W +: INSTR_W] : resp_data[INSTR_W-1:0];
      end
      if (beat == beat_t'(BEATS - 1)) begin
        tag_mem[index_q][victim] <= tag_q;
      end
    end
  end

  // Ready only answers an outstanding fetch
  a_ready_has_read: assert property (@(posedge clk) disable iff (!reset)
    instr_ready |-> instr_read);

endmodule

// ==== hw/l1_cache.sv ====
/*
 * Split L1 top: instruction and data caches share one tagged memory bus.
 * Memory itself lives outside this block.
 */
`timescale 1ns/1ps

module l1_cache
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      instr_read,
  input  addr_t     instr_address,
  input  logic      mem_read,
  input  logic      mem_write,
  input  addr_t     data_address,
  input  word_t     write_data,
  output instr_t    instr_data,
  output logic      instr_ready,
  output word_t     data_response,
  output logic      data_ready,
  output logic      bus_reqcyc,
  output bus_word_t bus_req,
  output bus_tag_t  bus_reqtag,
  output logic      bus_respack,
  input  logic      bus_reqack,
  input  logic      bus_respcyc,
  input  bus_word_t bus_resp,
  input  bus_tag_t  bus_resptag
);

  // Instruction cache side of the arbiter
  logic      ic_req_cyc, ic_req_last, ic_resp_ack, ic_req_ack, ic_resp_cyc;
  bus_word_t ic_req, ic_resp_data;
  bus_tag_t  ic_req_tag;

  // Data cache side
  logic      dc_req_cyc, dc_req_last, dc_resp_ack, dc_req_ack, dc_resp_cyc;
  bus_word_t dc_req, dc_resp_data;
  bus_tag_t  dc_req_tag;

  instr_cache u_instr_cache (
    .clk, .reset, .instr_read, .instr_address, .instr_data, .instr_ready,
    .req_cyc(ic_req_cyc), .req(ic_req), .req_tag(ic_req_tag),
    .req_last(ic_req_last), .resp_ack(ic_resp_ack), .req_ack(ic_req_ack),
    .resp_cyc(ic_resp_cyc), .resp_data(ic_resp_data)
  );

  data_cache u_data_cache (
    .clk, .reset, .mem_read, .mem_write, .data_address, .write_data,
    .data_response, .data_ready,
    .req_cyc(dc_req_cyc), .req(dc_req), .req_tag(dc_req_tag),
    .req_last(dc_req_last), .resp_ack(dc_resp_ack), .req_ack(dc_req_ack),
    .resp_cyc(dc_resp_cyc), .resp_data(dc_resp_data)
  );

  bus_arbiter u_bus_arbiter (
    .clk, .reset,
    .instr_req_cyc(ic_req_cyc), .instr_req(ic_req), .instr_req_tag(ic_req_tag),
    .instr_req_last(ic_req_last), .instr_resp_ack(ic_resp_ack),
    .instr_req_ack(ic_req_ack), .instr_resp_cyc(ic_resp_cyc),
    .instr_resp_data(ic_resp_data),
    .data_req_cyc(dc_req_cyc), .data_req(dc_req), .data_req_tag(dc_req_tag),
    .data_req_last(dc_req_last), .data_resp_ack(dc_resp_ack),
    .data_req_ack(dc_req_ack), .data_resp_cyc(dc_resp_cyc),
    .data_resp_data(dc_resp_data),
    .bus_reqcyc, .bus_req, .bus_reqtag, .bus_respack,
    .bus_reqack, .bus_respcyc, .bus_resp, .bus_resptag
  );

endmodule

// ==== l1_cache.f ====
hw/cache_pkg.sv
hw/instr_cache.sv
hw/data_cache.sv
hw/bus_arbiter.sv
hw/l1_cache.sv
verification/mem_model.sv
verification/l1_cache_tb.sv

// ==== verification/l1_cache_tb.sv ====
/*
 * Testbench for the split L1 cache with a behavioral memory on the bus.
 * Instruction and data regions never overlap, as the caches are not coherent.
 * Stimulus 2 ns after the rising edge, outputs sampled on the falling edge.
 */
`timescale 1ns/1ps

module l1_cache_tb
  import cache_pkg::*;
();

  // Address regions per test
  localparam addr_t INSTR_BASE  = 32'h0000_1000;
  localparam addr_t RAND_I_BASE = 32'h0000_8000;
  localparam addr_t DATA_BASE   = 32'h0002_0000;
  localparam addr_t EVICT_BASE  = 32'h0003_0000;
  localparam addr_t RAND_D_BASE = 32'h0004_0000;

  localparam int FETCH_LINES = 6;
  localparam int DATA_WORDS  = 8;
  localparam int EVICT_LINES = 6;
  localparam int MIXED_REQS  = 16;
  // Every test issues three requests per unit, the mixed test two
  localparam int REQ_TOTAL = 3 * (FETCH_LINES + DATA_WORDS + EVICT_LINES) + 2 * MIXED_REQS;
  localparam int WATCHDOG_CYCLES = 200 * REQ_TOTAL + 8;

  logic      clk;
  logic      reset;
  logic      instr_read;
  addr_t     instr_address;
  logic      mem_read;
  logic      mem_write;
  addr_t     data_address;
  word_t     write_data;
  instr_t    instr_data;
  logic      instr_ready;
  word_t     data_response;
  logic      data_ready;
  logic      bus_reqcyc;
  bus_word_t bus_req;
  bus_tag_t  bus_reqtag;
  logic      bus_respack;
  logic      bus_reqack;
  logic      bus_respcyc;
  bus_word_t bus_resp;
  bus_tag_t  bus_resptag;

  int     check_count;
  int     error_count;
  int     checks_before;
  int     errors_before;
  integer seed;

  // Shadow of completed processor writes
  word_t shadow [addr_t];

  addr_t rand_iaddr [MIXED_REQS];
  addr_t rand_daddr [MIXED_REQS];
  logic  rand_write [MIXED_REQS];
  word_t rand_value [MIXED_REQS];

  l1_cache u_l1_cache (
    .clk, .reset, .instr_read, .instr_address, .mem_read, .mem_write,
    .data_address, .write_data, .instr_data, .instr_ready, .data_response,
    .data_ready, .bus_reqcyc, .bus_req, .bus_reqtag, .bus_respack,
    .bus_reqack, .bus_respcyc, .bus_resp, .bus_resptag
  );

  mem_model u_mem_model (
    .clk, .reset, .bus_reqcyc, .bus_req, .bus_reqtag, .bus_reqack,
    .bus_respcyc, .bus_resp, .bus_resptag, .bus_respack
  );

  always #10 clk = ~clk;

  // Memory content before any write
  function automatic word_t address_pattern(input addr_t a);
    return {a ^ 32'h9e37_79b9, {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e};
  endfunction

  function automatic word_t expected_word(input addr_t a);
    addr_t key;
    key = {a[ADDR_W-1:3], 3'b000};
    if (shadow.exists(key)) begin
      return shadow[key];
    end
    return address_pattern(key);
  endfunction

  task automatic check_idle(input string when_text);
    check_count++;
    if (instr_ready !== 1'b0 || data_ready !== 1'b0 || bus_reqcyc !== 1'b0 ||
        bus_respack !== 1'b0) begin
      error_count++;
      $display("Fail at %0t: handshake outputs not low %s", $time, when_text);
    end
  endtask

  // Hold the fetch until ready; a hit must answer 2 cycles after sampling
  task automatic fetch_instr(input addr_t a, input logic hit);
    int waited;
    waited        = 0;
    instr_read    = 1'b1;
    instr_address = a;
    do begin
      @(negedge clk);
      waited++;
    end while (instr_ready !== 1'b1);
    if (hit) begin
      check_count++;
      if (waited - 1 != 2) begin
        error_count++;
        $display("Fail at %0t: hit on %h answered after %0d cycles, expected 2",
                 $time, a, waited - 1);
      end
    end
    @(posedge clk);
    #2;
    instr_read = 1'b0;
  endtask

  task automatic access_data(input addr_t a, input logic wr, input word_t d);
    mem_read     = !wr;
    mem_write    = wr;
    data_address = a;
    write_data   = d;
    do begin
      @(negedge clk);
    end while (data_ready !== 1'b1);
    @(posedge clk);
    #2;
    mem_read  = 1'b0;
    mem_write = 1'b0;
  endtask

  task automatic close_test(input string name);
    $display("Test %s finished: %0d checks, %0d errors", name,
             check_count - checks_before, error_count - errors_before);
    checks_before = check_count;
    errors_before = error_count;
  endtask

  // Compare at every ready pulse
  always @(negedge clk) begin
    word_t  want;
    instr_t want_instr;
    if (reset === 1'b1 && instr_ready === 1'b1) begin
      want       = expected_word(instr_address);
      want_instr = instr_address[2] ? want[INSTR_W +: INSTR_W] : want[INSTR_W-1:0];
      check_count++;
      if (instr_data !== want_instr) begin
        error_count++;
        $display("Fail at %0t: fetch %h returned %h, expected %h",
                 $time, instr_address, instr_data, want_instr);
      end
    end
    if (reset === 1'b1 && data_ready === 1'b1 && mem_read === 1'b1) begin
      want = expected_word(data_address);
      check_count++;
      if (data_response !== want) begin
        error_count++;
        $display("Fail at %0t: read %h returned %h, expected %h",
                 $time, data_address, data_response, want);
      end
    end
    // Completed write becomes the new expected value
    if (reset === 1'b1 && data_ready === 1'b1 && mem_write === 1'b1) begin
      shadow[{data_address[ADDR_W-1:3], 3'b000}] = write_data;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, a request never got its ready pulse",
             WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    addr_t       a;
    clk           = 1'b0;
    reset         = 1'b0;
    instr_read    = 1'b0;
    instr_address = '0;
    mem_read      = 1'b0;
    mem_write     = 1'b0;
    data_address  = '0;
    write_data    = '0;
    check_count   = 0;
    error_count   = 0;
    checks_before = 0;
    errors_before = 0;
    seed          = 32'h4c21_9c75;

    // Reset held over 4 rising edges
    repeat (3) begin
      @(negedge clk);
      check_idle("during reset");
    end
    @(posedge clk);
    #2;
    reset = 1'b1;
    @(negedge clk);
    check_idle("after reset");
    @(posedge clk);
    #2;
    close_test("reset");

    // Miss, hit on the same word, hit on the other half of the beat
    for (int l = 0; l < FETCH_LINES; l++) begin
      a = INSTR_BASE + addr_t'(l * 64 + l * 12);
      fetch_instr(a, 1'b0);
      fetch_instr(a, 1'b1);
      fetch_instr(a ^ 32'h4, 1'b1);
    end
    close_test("instruction fetch");

    // Write misses, write hits, read back, unwritten neighbours
    for (int i = 0; i < DATA_WORDS; i++) begin
      access_data(DATA_BASE + addr_t'(i * 72), 1'b1, {32'hcafe_0000 + i, 32'h1234_5678 ^ i});
    end
    for (int i = 0; i < DATA_WORDS / 2; i++) begin
      access_data(DATA_BASE + addr_t'(i * 72), 1'b1, {32'hbeef_0000 + i, ~(32'h1234_5678 ^ i)});
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      access_data(DATA_BASE + addr_t'(i * 72), 1'b0, '0);
    end
    for (int i = 0; i < DATA_WORDS / 2; i++) begin
      access_data(DATA_BASE + addr_t'(i * 72 + 16), 1'b0, '0);
    end
    close_test("data write and read");

    // Six lines in set 5 of a 4-way cache force dirty evictions
    for (int k = 0; k < EVICT_LINES; k++) begin
      access_data(EVICT_BASE + addr_t'(k * 1024 + 5 * 64 + 16), 1'b1,
                  {32'h05e7_0000 + k, 32'hfeed_0000 + k});
    end
    for (int k = 0; k < EVICT_LINES; k++) begin
      access_data(EVICT_BASE + addr_t'(k * 1024 + 5 * 64 + 16), 1'b0, '0);
      access_data(EVICT_BASE + addr_t'(k * 1024 + 5 * 64 + 24), 1'b0, '0);
    end
    close_test("dirty eviction");

    // Random traffic drawn up front so both ports see a fixed sequence
    for (int n = 0; n < MIXED_REQS; n++) begin
      rand_iaddr[n] = RAND_I_BASE + addr_t'(($random(seed) & 32'hff) << 2);
      rand_daddr[n] = RAND_D_BASE + addr_t'(($random(seed) & 32'h7f) << 3);
      rnd           = $random(seed);
      rand_write[n] = rnd[0];
      rand_value[n] = {$random(seed), $random(seed)};
    end
    fork
      begin
        for (int n = 0; n < MIXED_REQS; n++) begin
          fetch_instr(rand_iaddr[n], 1'b0);
        end
      end
      begin
        for (int n = 0; n < MIXED_REQS; n++) begin
          access_data(rand_daddr[n], rand_write[n], rand_value[n]);
        end
      end
    join
    close_test("mixed traffic");

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/mem_model.sv ====
/*
 * Behavioral memory on the tagged cache bus, testbench only.
 * Unwritten words read back a pattern built from the whole address.
 * One transaction at a time; ack and response delays are 0 to 3 cycles.
 */
`timescale 1ns/1ps

module mem_model
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      bus_reqcyc,
  input  bus_word_t bus_req,
  input  bus_tag_t  bus_reqtag,
  output logic      bus_reqack,
  output logic      bus_respcyc,
  output bus_word_t bus_resp,
  output bus_tag_t  bus_resptag,
  input  logic      bus_respack
);

  // Sparse store keyed by 8-byte aligned address
  bus_word_t store [addr_t];

  integer   seed;
  int       ack_wait;
  int       resp_wait;
  int       wr_beat;
  int       rd_beat;
  logic     writing;
  logic     reading;
  addr_t    wr_base;
  addr_t    rd_base;
  bus_tag_t rd_tag;

  function automatic bus_word_t initial_word(input addr_t a);
    return {a ^ 32'h9e37_79b9, {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e};
  endfunction

  function automatic bus_word_t read_word(input addr_t a);
    if (store.exists(a)) begin
      return store[a];
    end
    return initial_word(a);
  endfunction

  function automatic int random_delay();
    return $random(seed) & 3;
  endfunction

  initial begin
    seed        = 32'h4c21_9c75;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    bus_resptag = '0;
  end

  always @(posedge clk) begin
    if (!reset) begin
      bus_reqack  <= 1'b0;
      bus_respcyc <= 1'b0;
      writing     = 1'b0;
      reading     = 1'b0;
      ack_wait    = 0;
      resp_wait   = 0;
    end else begin
      // Request channel, one beat per ack
      if (bus_reqack) begin
        bus_reqack <= 1'b0;
        ack_wait = random_delay();
        if (writing) begin
          store[wr_base + addr_t'(wr_beat * 8)] = bus_req;
          wr_beat++;
          writing = (wr_beat < BEATS);
        end else if (bus_reqtag[BUS_TAG_W-1] == MEM_READ[BUS_TAG_W-1]) begin
          reading   = 1'b1;
          rd_base   = bus_req[ADDR_W-1:0];
          rd_tag    = bus_reqtag;
          rd_beat   = 0;
          resp_wait = random_delay();
        end else begin
          // Write-back address beat, data beats follow
          writing = 1'b1;
          wr_base = bus_req[ADDR_W-1:0];
          wr_beat = 0;
        end
      end else if (bus_reqcyc && !reading) begin
        if (ack_wait == 0) begin
          bus_reqack <= 1'b1;
        end else begin
          ack_wait--;
        end
      end
      // Response beats in ascending order, dropped once acked
      if (reading) begin
        if (bus_respcyc) begin
          if (bus_respack) begin
            bus_respcyc <= 1'b0;
            rd_beat++;
            reading   = (rd_beat < BEATS);
            resp_wait = random_delay();
          end
        end else if (resp_wait == 0) begin
          bus_respcyc <= 1'b1;
          bus_resp    <= read_word(rd_base + addr_t'(rd_beat * 8));
          bus_resptag <= rd_tag;
        end else begin
          resp_wait--;
        end
      end
    end
  end

endmodule
